// ==== Makefile ====
# Verilator build and run for the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
cache_pkg.sv
frame_store.sv
hit_lookup.sv
victim_select.sv
cache_controller.sv
l1_cache.sv
l1_cache_assertions.sv
tb_l1_cache.sv

// ==== cache_controller.sv ====
// FSM of the L1 data cache: hits, miss write-back and fetch, pass-through, init and flush
`timescale 1ns/1ps

module cache_controller (
    input  logic                         CLK,
    input  logic                         nRST,
    // processor bus
    input  logic                         proc_ren,
    input  logic                         proc_wen,
    input  cache_pkg::word_t             proc_addr,
    input  cache_pkg::word_t             proc_wdata,
    input  cache_pkg::be_t               proc_byte_en,
    output cache_pkg::word_t             proc_rdata,
    output logic                         proc_busy,
    // memory bus
    output logic                         mem_ren,
    output logic                         mem_wen,
    output cache_pkg::word_t             mem_addr,
    output cache_pkg::word_t             mem_wdata,
    output cache_pkg::be_t               mem_byte_en,
    input  cache_pkg::word_t             mem_rdata,
    input  logic                         mem_busy,
    input  logic                         flush,
    output logic                         flush_done,
    // lookup and victim results
    input  logic                         hit,
    input  logic                         hit_way,
    input  cache_pkg::word_t             hit_word,
    input  logic                         pass_through,
    input  logic                         victim_way,
    input  logic                         victim_valid,
    input  logic                         victim_dirty,
    input  logic [cache_pkg::TAG_W-1:0]  victim_tag,
    input  cache_pkg::word_t             victim_word,
    // frame store and last-used update
    input  cache_pkg::cache_set_t        rd_set,
    output logic [cache_pkg::SET_W-1:0]  sel,
    output logic                         wr_en,
    output cache_pkg::cache_set_t        wr_set,
    output cache_pkg::cache_set_t        wr_mask,
    output logic                         touch,
    output logic                         touch_way,
    output logic [31:0]                  misses,
    output logic [31:0]                  conflicts
);
    import cache_pkg::*;

    ctrl_state_t  state, next_state;
    // init walks sets, flush walks {set, way}
    logic [SET_W:0] walk, next_walk;
    logic         flush_req;
    word_t        fill_q;
    logic [31:0]  next_misses, next_conflicts;
    cache_addr_t  req;
    logic         req_any;
    word_t        lane_bits;
    cache_frame_t flush_frame;
    logic         flush_wb;

    assign req         = cache_addr_t'(proc_addr);
    assign req_any     = proc_ren | proc_wen;
    assign touch_way   = hit_way;
    assign flush_frame = rd_set.frames[walk[0]];
    assign flush_wb    = flush_frame.valid & flush_frame.dirty;

    // byte enables widened to bit lanes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_bits[8*b +: 8] = {8{proc_byte_en[b]}};
        end
    end

    always_comb begin
        case (state)
            INIT:    sel = walk[SET_W-1:0];
            FLUSH:   sel = walk[SET_W:1];
            default: sel = req.idx;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            walk      <= '0;
            flush_req <= 1'b0;
            misses    <= '0;
            conflicts <= '0;
        end else begin
            state     <= next_state;
            walk      <= next_walk;
            misses    <= next_misses;
            conflicts <= next_conflicts;
            // hold a flush pulse until the walk starts
            if (flush)
                flush_req <= 1'b1;
            else if (state == FLUSH)
                flush_req <= 1'b0;
        end
    end

    // word returned by memory, installed in UPDATE
    always_ff @(posedge CLK) begin
        if (state == FETCH && !mem_busy)
            fill_q <= mem_rdata;
    end

    always_comb begin
        next_state     = state;
        next_walk      = walk;
        next_misses    = misses;
        next_conflicts = conflicts;
        proc_busy      = 1'b1;
        proc_rdata     = '0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = '0;
        mem_wdata      = '0;
        mem_byte_en    = '1;
        wr_en          = 1'b0;
        wr_set         = '0;
        wr_mask        = '1;
        touch          = 1'b0;
        flush_done     = 1'b0;

        case (state)
            INIT: begin
                // wipe one whole set per cycle
                wr_en     = 1'b1;
                wr_mask   = '0;
                next_walk = walk + 1'b1;
                if (walk[SET_W-1:0] == SET_W'(N_SETS - 1)) begin
                    next_walk  = '0;
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (req_any && pass_through) begin
                    // straight to memory, write data only in its lanes
                    mem_ren     = proc_ren & ~proc_wen;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = proc_wdata & lane_bits;
                    mem_byte_en = proc_byte_en;
                    proc_busy   = mem_busy;
                    proc_rdata  = mem_rdata;
                end else if (req_any && hit) begin
                    proc_busy = 1'b0;
                    touch     = 1'b1;
                    if (proc_wen) begin
                        wr_en                         = 1'b1;
                        wr_set.frames[hit_way].data   = proc_wdata;
                        wr_set.frames[hit_way].dirty  = 1'b1;
                        wr_mask.frames[hit_way].data  = ~lane_bits;
                        wr_mask.frames[hit_way].dirty = 1'b0;
                    end else begin
                        proc_rdata = hit_word;
                    end
                end else if (req_any) begin
                    next_misses = misses + 32'd1;
                    if (victim_valid)
                        next_conflicts = conflicts + 32'd1;
                    next_state = (victim_valid && victim_dirty) ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, req.idx, 2'b00};
                mem_wdata = victim_word;
                if (!mem_busy)
                    next_state = FETCH;
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {req.tag, req.idx, 2'b00};
                if (!mem_busy)
                    next_state = UPDATE;
            end
            UPDATE: begin
                // install a fresh clean frame so the request then hits in LOOKUP
                wr_en                            = 1'b1;
                wr_set.frames[victim_way].valid  = 1'b1;
                wr_set.frames[victim_way].tag    = req.tag;
                wr_set.frames[victim_way].data   = fill_q;
                wr_mask.frames[victim_way]       = '0;
                next_state                       = LOOKUP;
            end
            FLUSH: begin
                if (flush_wb) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {flush_frame.tag, walk[SET_W:1], 2'b00};
                    mem_wdata = flush_frame.data;
                end
                // frame done once clean or its write-back accepted
                if (!flush_wb || !mem_busy) begin
                    wr_en                   = 1'b1;
                    wr_mask.frames[walk[0]] = '0;
                    next_walk               = walk + 1'b1;
                    if (&walk) begin
                        flush_done = 1'b1;
                        next_state = LOOKUP;
                    end
                end
            end
            default: next_state = INIT;
        endcase
    end

endmodule

// ==== cache_pkg.sv ====
// shared geometry, address fields, frame and set types and FSM states for the L1 data cache
package cache_pkg;

    // word and address width
    localparam int WORD_W = 32;

    // 8 sets of 2 one-word frames
    localparam int N_SETS = 8;
    localparam int SET_W  = 3;
    localparam int N_WAYS = 2;

    // tag takes what is left after index and byte offset
    localparam int TAG_W = WORD_W - SET_W - 2;

    // addresses at or above this go straight to memory
    localparam logic [WORD_W-1:0] NONCACHE_START = 32'hF000_0000;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        be_t;

    // processor address split into cache fields
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] idx;
        logic [1:0]       byte_off;
    } cache_addr_t;

    // one frame, 61 bits
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        word_t            data;
    } cache_frame_t;

    // both ways of a set, 122 bits
    typedef struct packed {
        cache_frame_t [N_WAYS-1:0] frames;
    } cache_set_t;

    // controller FSM
    typedef enum logic [2:0] {
        INIT, LOOKUP, WRITEBACK, FETCH, UPDATE, FLUSH
    } ctrl_state_t;

endpackage

// ==== frame_store.sv ====
// set-indexed frame array of the L1 data cache, masked write at the clock edge, async read
`timescale 1ns/1ps

module frame_store (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic [cache_pkg::SET_W-1:0]  sel,
    input  logic                         wr_en,
    input  cache_pkg::cache_set_t        wr_set,
    input  cache_pkg::cache_set_t        wr_mask,
    output cache_pkg::cache_set_t        rd_set
);
    import cache_pkg::*;

    cache_set_t sets [N_SETS];

    // mask bit at 0 takes the new bit, mask bit at 1 keeps the old one
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                sets[s] <= '0;
            end
        end else if (wr_en) begin
            sets[sel] <= (sets[sel] & wr_mask) | (wr_set & ~wr_mask);
        end
    end

    // read of the selected set is visible in the same cycle
    assign rd_set = sets[sel];

endmodule

// ==== hit_lookup.sv ====
// tag compare over both ways of the selected set, plus the non-cacheable address check
`timescale 1ns/1ps

module hit_lookup (
    input  cache_pkg::cache_set_t  rd_set,
    input  cache_pkg::cache_addr_t addr,
    output logic                   hit,
    output logic                   hit_way,
    output cache_pkg::word_t       hit_word,
    output logic                   pass_through
);
    import cache_pkg::*;

    always_comb begin
        hit          = 1'b0;
        hit_way      = 1'b0;
        hit_word     = '0;
        pass_through = addr >= NONCACHE_START;

        // only cacheable addresses can hit
        if (!pass_through) begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (rd_set.frames[w].valid && rd_set.frames[w].tag == addr.tag) begin
                    hit      = 1'b1;
                    hit_way  = 1'(w);
                    hit_word = rd_set.frames[w].data;
                end
            end
        end
    end

endmodule

// ==== l1_cache.sv ====
// top level of the 2-way write-back L1 data cache between the processor and memory buses
`timescale 1ns/1ps

module l1_cache (
    input  logic               CLK,
    input  logic               nRST,
    // processor bus
    input  logic               proc_ren,
    input  logic               proc_wen,
    input  cache_pkg::word_t   proc_addr,
    input  cache_pkg::word_t   proc_wdata,
    input  cache_pkg::be_t     proc_byte_en,
    output cache_pkg::word_t   proc_rdata,
    output logic               proc_busy,
    // memory bus
    output logic               mem_ren,
    output logic               mem_wen,
    output cache_pkg::word_t   mem_addr,
    output cache_pkg::word_t   mem_wdata,
    output cache_pkg::be_t     mem_byte_en,
    input  cache_pkg::word_t   mem_rdata,
    input  logic               mem_busy,
    // flush and statistics
    input  logic               flush,
    output logic               flush_done,
    output logic [31:0]        misses,
    output logic [31:0]        conflicts
);
    import cache_pkg::*;

    logic [SET_W-1:0] sel;
    logic             wr_en;
    cache_set_t       wr_set, wr_mask, rd_set;
    logic             hit, hit_way, pass_through;
    word_t            hit_word;
    logic             touch, touch_way;
    logic             victim_way, victim_valid, victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    word_t            victim_word;

    frame_store u_store (
        .CLK(CLK), .nRST(nRST), .sel(sel), .wr_en(wr_en),
        .wr_set(wr_set), .wr_mask(wr_mask), .rd_set(rd_set)
    );

    hit_lookup u_lookup (
        .rd_set(rd_set), .addr(proc_addr), .hit(hit), .hit_way(hit_way),
        .hit_word(hit_word), .pass_through(pass_through)
    );

    victim_select u_victim (
        .CLK(CLK), .nRST(nRST), .sel(sel), .rd_set(rd_set),
        .touch(touch), .touch_way(touch_way), .victim_way(victim_way),
        .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_word(victim_word)
    );

    cache_controller u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .proc_addr(proc_addr),
        .proc_wdata(proc_wdata), .proc_byte_en(proc_byte_en),
        .proc_rdata(proc_rdata), .proc_busy(proc_busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy),
        .flush(flush), .flush_done(flush_done),
        .hit(hit), .hit_way(hit_way), .hit_word(hit_word), .pass_through(pass_through),
        .victim_way(victim_way), .victim_valid(victim_valid),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag), .victim_word(victim_word),
        .rd_set(rd_set), .sel(sel), .wr_en(wr_en), .wr_set(wr_set), .wr_mask(wr_mask),
        .touch(touch), .touch_way(touch_way),
        .misses(misses), .conflicts(conflicts)
    );

endmodule

// ==== l1_cache_assertions.sv ====
// bus rule assertions for the L1 data cache, bound into l1_cache by the testbench
`timescale 1ns/1ps

module l1_cache_assertions (
    input logic             CLK,
    input logic             nRST,
    input logic             proc_busy,
    input logic             mem_ren,
    input logic             mem_wen,
    input cache_pkg::word_t mem_addr,
    input logic             mem_busy,
    input logic             flush_done
);
    import cache_pkg::*;

    // cycles since reset, stops once INIT is over
    int init_cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            init_cnt <= 0;
        end else if (init_cnt < N_SETS) begin
            init_cnt <= init_cnt + 1;
        end
    end

    a_one_mem_request: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen)) else $error("mem_ren and mem_wen are both high");

    a_busy_in_init: assert property (@(posedge CLK) disable iff (!nRST)
        (init_cnt < N_SETS) |-> proc_busy) else $error("proc_busy low during INIT");

    a_flush_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done) else $error("flush_done longer than one cycle");

    // a stalled memory request keeps its address
    a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr))
        else $error("mem_addr changed while mem_busy was high");

endmodule

// ==== tb_l1_cache.sv ====
// testbench for the L1 data cache, random accesses and flushes checked against two models
`timescale 1ns/1ps

module tb_l1_cache;
    import cache_pkg::*;

    localparam int N_OPS       = 400;
    localparam int CYCLE_LIMIT = 40 * N_OPS;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        proc_ren, proc_wen;
    word_t       proc_addr, proc_wdata, proc_rdata;
    be_t         proc_byte_en;
    logic        proc_busy;
    logic        mem_ren, mem_wen;
    word_t       mem_addr, mem_wdata;
    be_t         mem_byte_en;
    word_t       mem_rdata = '0;
    logic        mem_busy = 1'b0;
    logic        flush;
    logic        flush_done;
    logic [31:0] misses, conflicts;

    // sparse memory model
    word_t       mem_words [word_t];
    logic [1:0]  mem_wait = 2'd0;
    int          mem_writes = 0;
    word_t       mem_rnd;

    // reference image of the 64-word window and the 4 non-cacheable words
    word_t       ref_img [64];
    logic        written [64];
    word_t       ref_pt [4];
    // 2-way tag model holding the 3-bit window tag
    logic        m_valid [N_SETS][2];
    logic        m_dirty [N_SETS][2];
    logic [2:0]  m_tag [N_SETS][2];
    logic        m_last [N_SETS];
    logic [31:0] exp_misses, exp_conflicts;
    int          exp_writes;

    int          seed;
    int          cycles = 0;
    int          rst_cycle, done_cycle;
    int          n_mismatch = 0;
    int          n_other = 0;
    word_t       rnd, wdata;
    logic [2:0]  ts;

    l1_cache DUT (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .proc_addr(proc_addr),
        .proc_wdata(proc_wdata), .proc_byte_en(proc_byte_en),
        .proc_rdata(proc_rdata), .proc_busy(proc_busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy),
        .flush(flush), .flush_done(flush_done), .misses(misses), .conflicts(conflicts)
    );

    bind l1_cache l1_cache_assertions checks (
        .CLK(CLK), .nRST(nRST), .proc_busy(proc_busy), .mem_ren(mem_ren),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_busy(mem_busy), .flush_done(flush_done)
    );

    always #2 CLK = ~CLK;

    function automatic word_t fill_pattern(input word_t a);
        return a ^ 32'h6B3C_91E7;
    endfunction

    function automatic word_t lane_mask(input be_t be);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input be_t be);
        return (old & ~lane_mask(be)) | (nw & lane_mask(be));
    endfunction

    function automatic word_t mem_read(input word_t a);
        if (mem_words.exists(a))
            return mem_words[a];
        return fill_pattern(a);
    endfunction

    // window word w is tag w[5:3], set w[2:0]
    function automatic word_t window_addr(input logic [5:0] w);
        return {24'h00_0040, w, 2'b00};
    endfunction

    // single byte, half word or full word
    function automatic be_t pick_byte_en(input logic [3:0] k);
        if (k[1:0] == 2'd0)
            return 4'b0001 << k[3:2];
        if (k[1:0] == 2'd1)
            return k[2] ? 4'b1100 : 4'b0011;
        return 4'b1111;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s count is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_totals();
        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    endtask

    // memory bus slave with 0 to 3 busy cycles per transfer
    always @(posedge CLK) begin
        if (nRST && (mem_ren || mem_wen)) begin
            if (!mem_busy) begin
                if (mem_wen) begin
                    mem_words[mem_addr] = merge_bytes(mem_read(mem_addr), mem_wdata, mem_byte_en);
                    mem_writes++;
                end
                mem_rnd  = $random(seed);
                mem_wait = mem_rnd[1:0];
            end else begin
                mem_wait = mem_wait - 2'd1;
            end
        end
        #1 mem_busy = (mem_wait != 2'd0);
        #1 mem_rdata = mem_read(mem_addr);
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            report_totals();
            $display("TEST FAILED");
            $finish;
        end
    end

    // one processor request, held until proc_busy is low at an edge
    task automatic run_access(input logic wr, input word_t addr, input word_t wd, input be_t be);
        logic [5:0] w;
        logic [2:0] s;
        logic [2:0] t;
        logic       way;
        logic       found;
        proc_ren     = ~wr;
        proc_wen     = wr;
        proc_addr    = addr;
        proc_wdata   = wd;
        proc_byte_en = be;
        do begin
            @(posedge CLK);
        end while (proc_busy);
        done_cycle = cycles;
        w = addr[7:2];
        s = addr[4:2];
        t = addr[7:5];
        if (addr >= NONCACHE_START) begin
            if (wr) begin
                if (!mem_wen) begin
                    n_other++;
                    $display("ERROR at %0t: pass-through write is not on the memory bus", $time);
                end
                check_word("pass-through address", mem_addr, addr);
                check_word("pass-through write data", mem_wdata, wd & lane_mask(be));
                exp_writes++;
                ref_pt[addr[3:2]] = merge_bytes(ref_pt[addr[3:2]], wd, be);
            end else begin
                check_word("pass-through read", proc_rdata, ref_pt[addr[3:2]]);
            end
        end else begin
            found = 1'b0;
            way   = 1'b0;
            for (int i = 0; i < 2; i++) begin
                if (m_valid[s][i] && m_tag[s][i] == t) begin
                    found = 1'b1;
                    way   = 1'(i);
                end
            end
            if (!found) begin
                // victim is the way not last used
                way        = ~m_last[s];
                exp_misses = exp_misses + 32'd1;
                if (m_valid[s][way])
                    exp_conflicts = exp_conflicts + 32'd1;
                if (m_valid[s][way] && m_dirty[s][way])
                    exp_writes++;
                m_valid[s][way] = 1'b1;
                m_dirty[s][way] = 1'b0;
                m_tag[s][way]   = t;
            end
            m_dirty[s][way] = m_dirty[s][way] | wr;
            m_last[s]       = way;
            if (wr) begin
                ref_img[w] = merge_bytes(ref_img[w], wd, be);
                written[w] = 1'b1;
            end else begin
                check_word("cached read", proc_rdata, ref_img[w]);
            end
        end
        check_count("misses", misses, exp_misses);
        check_count("conflicts", conflicts, exp_conflicts);
        #1;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
        do begin
            @(posedge CLK);
        end while (!flush_done);
        #1;
        // dirty frames go back to memory, then every frame is empty
        for (int s = 0; s < N_SETS; s++) begin
            for (int i = 0; i < 2; i++) begin
                if (m_valid[s][i] && m_dirty[s][i])
                    exp_writes++;
                m_valid[s][i] = 1'b0;
                m_dirty[s][i] = 1'b0;
            end
        end
        for (int i = 0; i < 64; i++) begin
            if (written[i])
                check_word("memory after flush", mem_read(window_addr(6'(i))), ref_img[i]);
        end
    endtask

    initial begin
        seed          = 52;
        nRST          = 1'b0;
        proc_ren      = 1'b0;
        proc_wen      = 1'b0;
        proc_addr     = '0;
        proc_wdata    = '0;
        proc_byte_en  = '0;
        flush         = 1'b0;
        exp_misses    = '0;
        exp_conflicts = '0;
        exp_writes    = 0;
        for (int i = 0; i < 64; i++) begin
            ref_img[i] = fill_pattern(window_addr(6'(i)));
            written[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            ref_pt[i] = fill_pattern(NONCACHE_START | {28'd0, 2'(i), 2'b00});
        end
        for (int s = 0; s < N_SETS; s++) begin
            m_last[s] = 1'b0;
            for (int i = 0; i < 2; i++) begin
                m_valid[s][i] = 1'b0;
                m_dirty[s][i] = 1'b0;
                m_tag[s][i]   = '0;
            end
        end
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
        rst_cycle = cycles;

        // a pass-through read waits only for INIT
        run_access(1'b0, NONCACHE_START, '0, 4'hF);
        if (done_cycle - rst_cycle < N_SETS) begin
            n_other++;
            $display("ERROR: a request completed while the cache was still initializing");
        end

        for (int op = 1; op < N_OPS; op++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            ts    = rnd[15:13];
            if (ts > 3'd5)
                ts = ts - 3'd6;
            if (rnd[3:0] == 4'd0) begin
                flush_cache();
            end else if (rnd[3:0] <= 4'd2) begin
                run_access(rnd[4], NONCACHE_START | {28'd0, rnd[6:5], 2'b00}, wdata,
                           pick_byte_en(rnd[20:17]));
            end else begin
                run_access(rnd[4], window_addr({ts, rnd[12:10]}), wdata,
                           pick_byte_en(rnd[20:17]));
            end
        end
        flush_cache();
        check_count("memory writes", mem_writes, exp_writes);

        report_totals();
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== victim_select.sv ====
// last-used bit per set and the victim frame it points to, for the 2-way L1 data cache
`timescale 1ns/1ps

module victim_select (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic [cache_pkg::SET_W-1:0]  sel,
    input  cache_pkg::cache_set_t        rd_set,
    input  logic                         touch,
    input  logic                         touch_way,
    output logic                         victim_way,
    output logic                         victim_valid,
    output logic                         victim_dirty,
    output logic [cache_pkg::TAG_W-1:0]  victim_tag,
    output cache_pkg::word_t             victim_word
);
    import cache_pkg::*;

    // way last used, one bit per set
    logic [N_SETS-1:0] last_used;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[sel] <= touch_way;
        end
    end

    // evict the other way
    assign victim_way   = ~last_used[sel];
    assign victim_valid = rd_set.frames[victim_way].valid;
    assign victim_dirty = rd_set.frames[victim_way].dirty;
    assign victim_tag   = rd_set.frames[victim_way].tag;
    assign victim_word  = rd_set.frames[victim_way].data;

endmodule
